// ==== design/bus_cycle_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_engine #(
    parameter int addr_w = 16
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        msg_start,
    input  wire spi_bridge_pkg::cmd_e  cmd,
    input  wire  [3:0]                 byte_idx,
    input  wire  [7:0]                 rx_byte,
    input  wire                        arg_valid,
    input  wire                        phi,
    input  wire  [7:0]                 bus_rddata,
    output logic [addr_w-1:0]          bus_a,
    output logic [7:0]                 bus_wrdata,
    output logic                       bus_wrdata_en,
    output logic                       bus_rd_n,
    output logic                       bus_wr_n,
    output logic                       bus_mreq_n,
    output logic                       bus_iorq_n,
    output logic [7:0]                 rd_data,
    output logic                       rd_done
);

    localparam int addr_bytes = addr_w / 8;

    spi_bridge_pkg::bus_state_e state;

    logic phi_q;
    logic phi_fall;
    logic phi_rise;
    logic is_mem;
    logic is_io;
    logic is_read;
    logic is_write;

    assign phi_fall = phi_q && !phi;
    assign phi_rise = !phi_q && phi;

    assign is_mem   = cmd == spi_bridge_pkg::cmd_mem_write || cmd == spi_bridge_pkg::cmd_mem_read;
    assign is_io    = cmd == spi_bridge_pkg::cmd_io_write || cmd == spi_bridge_pkg::cmd_io_read;
    assign is_read  = cmd == spi_bridge_pkg::cmd_mem_read || cmd == spi_bridge_pkg::cmd_io_read;
    assign is_write = cmd == spi_bridge_pkg::cmd_mem_write || cmd == spi_bridge_pkg::cmd_io_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phi_q         <= 1'b0;
            state         <= spi_bridge_pkg::bus_idle;
            bus_wrdata_en <= 1'b0;
            bus_rd_n      <= 1'b1;
            bus_wr_n      <= 1'b1;
            bus_mreq_n    <= 1'b1;
            bus_iorq_n    <= 1'b1;
            rd_done       <= 1'b0;
        end else begin
            phi_q   <= phi;
            rd_done <= 1'b0;
            if (msg_start) begin  // new message aborts the cycle
                state         <= spi_bridge_pkg::bus_idle;
                bus_wrdata_en <= 1'b0;
                bus_rd_n      <= 1'b1;
                bus_wr_n      <= 1'b1;
                bus_mreq_n    <= 1'b1;
                bus_iorq_n    <= 1'b1;
            end else begin
                case (state)
                    spi_bridge_pkg::bus_idle: begin
                        if (arg_valid) begin
                            if (is_read && byte_idx == 4'(addr_bytes))
                                state <= spi_bridge_pkg::bus_t1;  // last address byte
                            if (is_write && byte_idx == 4'(addr_bytes + 1))
                                state <= spi_bridge_pkg::bus_t1;  // data byte
                        end
                    end
                    spi_bridge_pkg::bus_t1: begin
                        if (phi_fall) begin
                            bus_mreq_n    <= !is_mem;
                            bus_iorq_n    <= !is_io;
                            bus_rd_n      <= !is_read;
                            bus_wrdata_en <= is_write;
                            state         <= spi_bridge_pkg::bus_t2;
                        end
                    end
                    spi_bridge_pkg::bus_t2: begin
                        if (phi_fall) begin
                            bus_wr_n <= !is_write;
                            state    <= spi_bridge_pkg::bus_t3;
                        end
                    end
                    spi_bridge_pkg::bus_t3: begin
                        if (phi_fall) begin
                            bus_rd_n   <= 1'b1;
                            bus_wr_n   <= 1'b1;
                            bus_mreq_n <= 1'b1;
                            bus_iorq_n <= 1'b1;
                            rd_done    <= is_read;
                            state      <= spi_bridge_pkg::bus_done;
                        end
                    end
                    spi_bridge_pkg::bus_done: begin
                        if (phi_rise) begin  // hold write data past the strobes
                            bus_wrdata_en <= 1'b0;
                            state         <= spi_bridge_pkg::bus_idle;
                        end
                    end
                    default: state <= spi_bridge_pkg::bus_idle;
                endcase
            end
        end
    end

    // address is sent low byte first
    always_ff @(posedge clk) begin
        if (state == spi_bridge_pkg::bus_idle && arg_valid) begin
            for (int i = 0; i < addr_bytes; i++) begin
                if (byte_idx == 4'(i + 1))
                    bus_a[8*i +: 8] <= rx_byte;
            end
            if (byte_idx == 4'(addr_bytes + 1))
                bus_wrdata <= rx_byte;
        end
        if (state == spi_bridge_pkg::bus_t3 && phi_fall && is_read)
            rd_data <= bus_rddata;  // sampled as the strobes release
    end

endmodule

`default_nettype wire

// ==== design/cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_parser #(
    parameter int key_bytes = 8,
    parameter int addr_w    = 16
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        msg_start,
    input  wire                        msg_end,
    input  wire  [7:0]                 rx_byte,
    input  wire                        rx_valid,
    output spi_bridge_pkg::cmd_e       cmd,
    output logic [3:0]                 byte_idx,
    output logic [key_bytes*8-1:0]     operand,
    output logic                       arg_valid
);

    typedef enum logic [1:0] {
        ps_idle,
        ps_opcode,
        ps_operand
    } parse_state_e;

    parse_state_e state;

    // address bytes plus the data byte must stay below the saturation index
    if (addr_w % 8 != 0 || addr_w / 8 + 1 >= 15 || key_bytes < 2) begin : g_param_check
        $error("cmd_parser: unsupported addr_w or key_bytes");
    end

    assign arg_valid = rx_valid && (state == ps_operand);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ps_idle;
            cmd      <= spi_bridge_pkg::cmd_nop;
            byte_idx <= 4'd0;
        end else if (msg_start) begin
            state    <= ps_opcode;
            byte_idx <= 4'd0;
        end else if (msg_end) begin
            state <= ps_idle;  // cmd stays for end-of-message actions
        end else if (rx_valid && state != ps_idle) begin
            if (byte_idx != spi_bridge_pkg::byte_idx_max)
                byte_idx <= byte_idx + 4'd1;
            if (state == ps_opcode) begin
                cmd   <= spi_bridge_pkg::cmd_e'(rx_byte);
                state <= ps_operand;
            end
        end
    end

    // first operand byte ends up in the low byte
    always_ff @(posedge clk) begin
        if (arg_valid)
            operand <= {rx_byte, operand[key_bytes*8-1:8]};
    end

endmodule

`default_nettype wire

// ==== design/reply_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module reply_mux (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire spi_bridge_pkg::cmd_e  cmd,
    input  wire  [7:0]                 rd_data,
    input  wire                        rd_done,
    input  wire                        bus_owned,
    input  wire                        tx_ack,
    output logic [7:0]                 tx_byte
);

    logic       rd_pend;  // read data waiting for the host
    logic       is_bus_cmd;
    logic [7:0] status;

    assign is_bus_cmd = cmd inside {spi_bridge_pkg::cmd_bus_acquire,
                                    spi_bridge_pkg::cmd_bus_release,
                                    spi_bridge_pkg::cmd_mem_write,
                                    spi_bridge_pkg::cmd_mem_read,
                                    spi_bridge_pkg::cmd_io_write,
                                    spi_bridge_pkg::cmd_io_read};

    assign status = is_bus_cmd ? {7'd0, bus_owned} : spi_bridge_pkg::status_idle_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            tx_byte <= 8'h00;
        end else if (rd_done) begin
            rd_pend <= 1'b1;
            tx_byte <= rd_data;
        end else if (!(rd_pend && !tx_ack)) begin
            rd_pend <= 1'b0;  // consumed, back to status
            tx_byte <= status;
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_bridge_pkg.sv ====
`default_nettype none

package spi_bridge_pkg;

    // host opcodes, first byte of every message
    typedef enum logic [7:0] {
        cmd_nop         = 8'h00,
        cmd_reset       = 8'h01,
        cmd_set_keys    = 8'h10,
        cmd_bus_acquire = 8'h20,
        cmd_bus_release = 8'h21,
        cmd_mem_write   = 8'h22,
        cmd_mem_read    = 8'h23,
        cmd_io_write    = 8'h24,
        cmd_io_read     = 8'h25
    } cmd_e;

    // bus cycle engine, t1..t3 step on phi falling edges
    typedef enum logic [2:0] {
        bus_idle = 3'd0,
        bus_t1   = 3'd1,
        bus_t2   = 3'd2,
        bus_t3   = 3'd3,
        bus_done = 3'd4
    } bus_state_e;

    localparam logic [7:0] status_idle_byte = 8'h00;  // reply when nothing to report
    localparam logic [3:0] byte_idx_max     = 4'd15;  // byte counter saturates here

endpackage

`default_nettype wire

// ==== design/spi_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top #(
    parameter int key_bytes = 8,
    parameter int addr_w    = 16
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    ssel_n,
    input  wire                    sclk,
    input  wire                    mosi,
    output logic                   miso,
    input  wire                    phi,
    output logic [addr_w-1:0]      bus_a,
    input  wire  [7:0]             bus_rddata,
    output logic [7:0]             bus_wrdata,
    output logic                   bus_wrdata_en,
    output logic                   bus_rd_n,
    output logic                   bus_wr_n,
    output logic                   bus_mreq_n,
    output logic                   bus_iorq_n,
    output logic                   reset_req,
    output logic [key_bytes*8-1:0] keys,
    output logic                   busreq
);

    logic                   msg_start;
    logic                   msg_end;
    logic [7:0]             rx_byte;
    logic                   rx_valid;
    logic [7:0]             tx_byte;
    logic                   tx_ack;
    spi_bridge_pkg::cmd_e   cmd;
    logic [3:0]             byte_idx;
    logic [key_bytes*8-1:0] operand;
    logic                   arg_valid;
    logic                   bus_owned;
    logic [7:0]             rd_data;
    logic                   rd_done;

    spi_slave u_spi (
        .clk(clk), .rst_n(rst_n), .ssel_n(ssel_n), .sclk(sclk), .mosi(mosi), .miso(miso),
        .msg_start(msg_start), .msg_end(msg_end), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .tx_byte(tx_byte), .tx_ack(tx_ack)
    );

    cmd_parser #(.key_bytes(key_bytes), .addr_w(addr_w)) u_parser (
        .clk(clk), .rst_n(rst_n), .msg_start(msg_start), .msg_end(msg_end),
        .rx_byte(rx_byte), .rx_valid(rx_valid), .cmd(cmd), .byte_idx(byte_idx),
        .operand(operand), .arg_valid(arg_valid)
    );

    sys_ctrl #(.key_bytes(key_bytes)) u_sys (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .msg_end(msg_end), .operand(operand),
        .phi(phi), .reset_req(reset_req), .keys(keys), .busreq(busreq),
        .bus_owned(bus_owned)
    );

    bus_cycle_engine #(.addr_w(addr_w)) u_engine (
        .clk(clk), .rst_n(rst_n), .msg_start(msg_start), .cmd(cmd), .byte_idx(byte_idx),
        .rx_byte(rx_byte), .arg_valid(arg_valid), .phi(phi), .bus_rddata(bus_rddata),
        .bus_a(bus_a), .bus_wrdata(bus_wrdata), .bus_wrdata_en(bus_wrdata_en),
        .bus_rd_n(bus_rd_n), .bus_wr_n(bus_wr_n), .bus_mreq_n(bus_mreq_n),
        .bus_iorq_n(bus_iorq_n), .rd_data(rd_data), .rd_done(rd_done)
    );

    reply_mux u_reply (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .rd_data(rd_data), .rd_done(rd_done),
        .bus_owned(bus_owned), .tx_ack(tx_ack), .tx_byte(tx_byte)
    );

endmodule

`default_nettype wire

// ==== design/spi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        ssel_n,
    input  wire        sclk,
    input  wire        mosi,
    output logic       miso,
    output logic       msg_start,
    output logic       msg_end,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    input  wire  [7:0] tx_byte,
    output logic       tx_ack
);

    logic [2:0] ssel_s;    // two sync stages plus edge history
    logic [2:0] sclk_s;
    logic [1:0] mosi_s;
    logic       active;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    logic [7:0] tx_shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ssel_s <= 3'b111;  // deselected, no false msg_start
            sclk_s <= 3'b000;
            mosi_s <= 2'b00;
        end else begin
            ssel_s <= {ssel_s[1:0], ssel_n};
            sclk_s <= {sclk_s[1:0], sclk};
            mosi_s <= {mosi_s[0], mosi};
        end
    end

    assign active    = !ssel_s[1];
    assign sclk_rise = active && sclk_s[1] && !sclk_s[2];
    assign sclk_fall = active && !sclk_s[1] && sclk_s[2];
    assign msg_start = ssel_s[2] && !ssel_s[1];
    assign msg_end   = !ssel_s[2] && ssel_s[1];

    // first rise of a byte takes the reply byte
    assign tx_ack = sclk_rise && (bit_cnt == 3'd0);

    // mode 0: MSB must be on the line before the first rise
    assign miso = (bit_cnt == 3'd0) ? tx_byte[7] : tx_shift[7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= sclk_rise && (bit_cnt == 3'd7);  // one clk after 8th rise
            if (msg_start)
                bit_cnt <= 3'd0;
            else if (sclk_rise)
                bit_cnt <= bit_cnt + 3'd1;  // wraps at byte boundary
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise)
            rx_byte <= {rx_byte[6:0], mosi_s[1]};  // msb first
        if (tx_ack)
            tx_shift <= tx_byte;
        else if (sclk_fall)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

endmodule

`default_nettype wire

// ==== design/sys_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl #(
    parameter int key_bytes = 8
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire spi_bridge_pkg::cmd_e  cmd,
    input  wire                        msg_end,
    input  wire  [key_bytes*8-1:0]     operand,
    input  wire                        phi,
    output logic                       reset_req,
    output logic [key_bytes*8-1:0]     keys,
    output logic                       busreq,
    output logic                       bus_owned
);

    logic phi_q;
    logic phi_fall;
    logic reset_pend;  // first stage of the reset pulse

    assign phi_fall  = phi_q && !phi;
    assign bus_owned = busreq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phi_q      <= 1'b0;
            reset_pend <= 1'b0;
            reset_req  <= 1'b0;
            keys       <= '0;
            busreq     <= 1'b0;
        end else begin
            phi_q      <= phi;
            reset_pend <= msg_end && (cmd == spi_bridge_pkg::cmd_reset);
            reset_req  <= reset_pend;  // single cycle, 2 clk after msg_end

            if (msg_end && cmd == spi_bridge_pkg::cmd_set_keys)
                keys <= operand;

            // bus request only moves on a phi falling edge
            if (phi_fall) begin
                if (cmd == spi_bridge_pkg::cmd_bus_acquire)
                    busreq <= 1'b1;
                else if (cmd == spi_bridge_pkg::cmd_bus_release)
                    busreq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/spi_bridge_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_assert (
    input wire                              clk,
    input wire                              rst_n,
    input wire                              msg_end,
    input wire spi_bridge_pkg::cmd_e        cmd,
    input wire                              reset_req,
    input wire                              phi,
    input wire                              busreq,
    input wire                              bus_rd_n,
    input wire                              bus_wr_n,
    input wire                              bus_mreq_n,
    input wire                              bus_iorq_n,
    input wire                              bus_wrdata_en,
    input wire spi_bridge_pkg::bus_state_e  eng_state
);

    int fail_cnt = 0;  // read by the testbench monitor

    // reset request is one clk wide, 2 clk after msg_end
    a_reset_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        msg_end && cmd == spi_bridge_pkg::cmd_reset |-> ##2 reset_req ##1 !reset_req)
        else begin
            $error("reset_req pulse missing or wider than one cycle");
            fail_cnt++;
        end

    a_reset_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(reset_req) |-> $past(msg_end, 2) && $past(cmd, 2) == spi_bridge_pkg::cmd_reset)
        else begin
            $error("reset_req raised without a reset message");
            fail_cnt++;
        end

    // busreq moves only after phi was seen high then low
    a_busreq_phi: assert property (@(posedge clk) disable iff (!rst_n)
        busreq != $past(busreq) |-> $past(phi, 2) && !$past(phi))
        else begin
            $error("busreq changed away from a phi falling edge");
            fail_cnt++;
        end

    a_strobe_owned: assert property (@(posedge clk) disable iff (!rst_n)
        !bus_mreq_n || !bus_iorq_n |-> busreq)
        else begin
            $error("bus strobe asserted while busreq is low");
            fail_cnt++;
        end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(!bus_rd_n && !bus_wr_n))
        else begin
            $error("rd_n and wr_n low together");
            fail_cnt++;
        end

    a_sel_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(!bus_mreq_n && !bus_iorq_n))
        else begin
            $error("mreq_n and iorq_n low together");
            fail_cnt++;
        end

    a_wr_data_en: assert property (@(posedge clk) disable iff (!rst_n)
        !bus_wr_n |-> bus_wrdata_en)
        else begin
            $error("wr_n low while write data is not driven");
            fail_cnt++;
        end

    a_idle_release: assert property (@(posedge clk) disable iff (!rst_n)
        eng_state == spi_bridge_pkg::bus_idle |->
            bus_rd_n && bus_wr_n && bus_mreq_n && bus_iorq_n)
        else begin
            $error("strobe held low while the engine is idle");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== dv/tb_spi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge;

    localparam int key_bytes      = 8;
    localparam int addr_w         = 16;
    localparam int n_msgs         = 12;
    localparam int max_bytes      = 9;
    localparam int timeout_cycles = n_msgs * max_bytes * 64 + 2000;

    logic        clk;
    logic        rst_n;
    logic        ssel_n;
    logic        sclk;
    logic        mosi;
    logic        miso;
    logic        phi;
    logic [15:0] bus_a;
    logic [7:0]  bus_rddata;
    logic [7:0]  bus_wrdata;
    logic        bus_wrdata_en;
    logic        bus_rd_n;
    logic        bus_wr_n;
    logic        bus_mreq_n;
    logic        bus_iorq_n;
    logic        reset_req;
    logic [63:0] keys;
    logic        busreq;

    logic [31:0] lfsr      = 32'h7aa8;
    logic [63:0] exp_keys  = '0;
    int          cycle_cnt = 0;
    int          phi_cnt   = 0;
    logic [15:0] wr_addr;      // last write seen on the bus
    logic [7:0]  wr_data;
    logic        wr_mem;
    logic        wr_io;
    int          wr_cnt    = 0;
    logic        wr_prev   = 1'b1;
    logic        rd_mem;
    logic        rd_io;
    int          rd_cnt    = 0;
    logic        rd_prev   = 1'b1;

    spi_bridge_top #(.key_bytes(key_bytes), .addr_w(addr_w)) dut (
        .clk(clk), .rst_n(rst_n), .ssel_n(ssel_n), .sclk(sclk), .mosi(mosi), .miso(miso),
        .phi(phi), .bus_a(bus_a), .bus_rddata(bus_rddata), .bus_wrdata(bus_wrdata),
        .bus_wrdata_en(bus_wrdata_en), .bus_rd_n(bus_rd_n), .bus_wr_n(bus_wr_n),
        .bus_mreq_n(bus_mreq_n), .bus_iorq_n(bus_iorq_n), .reset_req(reset_req),
        .keys(keys), .busreq(busreq)
    );

    bind spi_bridge_top spi_bridge_assert u_assert (
        .clk(clk), .rst_n(rst_n), .msg_end(msg_end), .cmd(cmd), .reset_req(reset_req),
        .phi(phi), .busreq(busreq), .bus_rd_n(bus_rd_n), .bus_wr_n(bus_wr_n),
        .bus_mreq_n(bus_mreq_n), .bus_iorq_n(bus_iorq_n), .bus_wrdata_en(bus_wrdata_en),
        .eng_state(u_engine.state)
    );

    // memory and i/o read model
    assign bus_rddata = bus_a[7:0] ^ bus_a[15:8] ^ (bus_iorq_n ? 8'h5a : 8'ha5);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        phi_cnt <= (phi_cnt == 5) ? 0 : phi_cnt + 1;
        phi     <= (phi_cnt < 3);  // clk/6
    end

    // record each bus cycle as its strobe falls
    always @(posedge clk) begin
        if (!bus_wr_n && wr_prev) begin
            wr_addr <= bus_a;
            wr_data <= bus_wrdata;
            wr_mem  <= !bus_mreq_n;
            wr_io   <= !bus_iorq_n;
            wr_cnt  <= wr_cnt + 1;
        end
        if (!bus_rd_n && rd_prev) begin
            rd_mem <= !bus_mreq_n;
            rd_io  <= !bus_iorq_n;
            rd_cnt <= rd_cnt + 1;
        end
        wr_prev <= bus_wr_n;
        rd_prev <= bus_rd_n;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles)
            stop_with_failure("timeout: the message sequence did not finish in time");
        else if (dut.u_assert.fail_cnt != 0)
            stop_with_failure("a bound protocol assertion failed");
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("MISMATCH at %0t: %s is %0h, expected %0h",
                                        $time, what, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic begin_message();
        @(posedge clk);
        ssel_n <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    // mode 0, sclk half period of 4 clk
    task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            sclk <= 1'b0;
            mosi <= tx[i];
            repeat (3) @(posedge clk);
            @(negedge clk);
            rx[i] = miso;  // sampled just ahead of the rise
            @(posedge clk);
            sclk <= 1'b1;
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic end_message();
        @(posedge clk);
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        ssel_n <= 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_value("keys", keys, exp_keys);  // only a key message may change them
    endtask

    task automatic send_reset();
        logic [7:0] rx;
        begin_message();
        xfer_byte(spi_bridge_pkg::cmd_reset, rx);
        end_message();
    endtask

    task automatic load_keys();
        logic [63:0] r;
        logic [7:0]  rx;
        begin_message();
        xfer_byte(spi_bridge_pkg::cmd_set_keys, rx);
        for (int i = 0; i < key_bytes; i++) begin
            take_bits(8, r);
            exp_keys[8*i +: 8] = r[7:0];  // first byte lands in the low byte
            xfer_byte(r[7:0], rx);
        end
        end_message();
    endtask

    task automatic set_busreq(input logic on);
        logic [7:0] rx;
        begin_message();
        xfer_byte(on ? spi_bridge_pkg::cmd_bus_acquire : spi_bridge_pkg::cmd_bus_release, rx);
        do @(negedge clk); while (busreq !== on);
        xfer_byte(8'h00, rx);
        check_value("status reply", rx, {7'd0, on});
        end_message();
    endtask

    task automatic bus_write(input logic io);
        logic [63:0] r;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  rx;
        int          n0;
        take_bits(16, r);
        a = r[15:0];
        take_bits(8, r);
        d = r[7:0];
        n0 = wr_cnt;
        begin_message();
        xfer_byte(io ? spi_bridge_pkg::cmd_io_write : spi_bridge_pkg::cmd_mem_write, rx);
        xfer_byte(a[7:0], rx);
        xfer_byte(a[15:8], rx);
        xfer_byte(d, rx);
        while (wr_cnt == n0 || !bus_wr_n || !bus_mreq_n || !bus_iorq_n)
            @(negedge clk);
        check_value("write address", wr_addr, a);
        check_value("write data", wr_data, d);
        check_value("write select {mreq, iorq}", {wr_mem, wr_io}, {!io, io});
        end_message();
    endtask

    task automatic bus_read(input logic io);
        logic [63:0] r;
        logic [15:0] a;
        logic [7:0]  rx;
        int          n0;
        take_bits(16, r);
        a = r[15:0];
        n0 = rd_cnt;
        begin_message();
        xfer_byte(io ? spi_bridge_pkg::cmd_io_read : spi_bridge_pkg::cmd_mem_read, rx);
        xfer_byte(a[7:0], rx);
        xfer_byte(a[15:8], rx);
        while (rd_cnt == n0 || !bus_rd_n || !bus_mreq_n || !bus_iorq_n)
            @(negedge clk);
        xfer_byte(8'h00, rx);  // reply slot
        check_value("read select {mreq, iorq}", {rd_mem, rd_io}, {!io, io});
        check_value("read reply", rx, a[7:0] ^ a[15:8] ^ (io ? 8'ha5 : 8'h5a));
        end_message();
    endtask

    initial begin
        rst_n  = 1'b0;
        ssel_n = 1'b1;
        sclk   = 1'b0;
        mosi   = 1'b0;
        phi    = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        send_reset();
        load_keys();
        set_busreq(1'b1);
        repeat (2) begin
            bus_write(1'b0);
            bus_write(1'b1);
            bus_read(1'b0);
            bus_read(1'b1);
        end
        set_busreq(1'b0);
        repeat (10) @(posedge clk);
        if (dut.u_assert.fail_cnt != 0) begin
            stop_with_failure("a bound protocol assertion failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/spi_bridge_pkg.sv
design/spi_slave.sv
design/cmd_parser.sv
design/sys_ctrl.sv
design/bus_cycle_engine.sv
design/reply_mux.sv
design/spi_bridge_top.sv
dv/spi_bridge_assert.sv
dv/tb_spi_bridge.sv
